/* list.f */
hdl/cpuPkg.sv
hdl/aluUnit.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/pipeCpu.sv
test/pipeCpu_assert.sv
test/pipeCpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= pipeCpuTb
FLIST     ?= list.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIMARGS   ?= +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) $(SIMARGS) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* test/pipeCpuTb.sv */
`timescale 1ns/1ps

module pipeCpuTb;

  logic           clk;
  logic           rst;
  cpuPkg::progT   prog;
  cpuPkg::retireT retire;
  cpuPkg::storeT  store;

  logic [31:0] progMem [64];
  int          progLen;
  logic [31:0] rngState = 32'h9328;
  logic [4:0]  expRd [$];
  logic [31:0] expData [$];
  logic [31:0] expAddr [$];
  logic [31:0] expStore [$];
  int          retireErrs = 0;
  int          storeErrs = 0;
  int          timeouts = 0;
  int          waitCycles;

  pipeCpu dut (
    .clk    (clk),
    .rst    (rst),
    .prog   (prog),
    .retire (retire),
    .store  (store)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [11:0] randImm();
    rngState = lcgNext(rngState);
    return rngState[27:16];
  endfunction

  function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rd, rs1, rs2,
                                       input logic [2:0] f3);
    return {f7, rs2, rs1, f3, rd, cpuPkg::opAluReg};
  endfunction

  function automatic logic [31:0] encI(input logic [6:0] op, input logic [4:0] rd, rs1,
                                       input logic [2:0] f3, input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  // store layout, beq uses it too
  function automatic logic [31:0] encS(input logic [6:0] op, input logic [4:0] rs1, rs2,
                                       input logic [2:0] f3, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
  endfunction

  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic subOp,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000:  return subOp ? a - b : a + b;
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return a + b;
    endcase
  endfunction

  task automatic emit(input logic [31:0] w);
    progMem[progLen] = w;
    progLen++;
  endtask

  task automatic buildProgram();
    logic [11:0] addrA;
    addrA = randImm() & 12'h0ff;
    progLen = 0;
    emit(encI(cpuPkg::opAluImm, 5'd1, 5'd0, 3'b000, randImm()));
    emit(encI(cpuPkg::opAluImm, 5'd2, 5'd0, 3'b000, randImm()));
    emit(encR(7'h00, 5'd3, 5'd1, 5'd2, 3'b000)); // x2 from mem, x1 from wb
    emit(encR(7'h20, 5'd4, 5'd3, 5'd1, 3'b000));
    emit(encR(7'h00, 5'd5, 5'd4, 5'd3, 3'b100));
    emit(encR(7'h00, 5'd6, 5'd5, 5'd2, 3'b110));
    emit(encR(7'h00, 5'd7, 5'd6, 5'd4, 3'b111));
    emit(encI(cpuPkg::opAluImm, 5'd8, 5'd7, 3'b100, randImm()));
    emit(encI(cpuPkg::opAluImm, 5'd9, 5'd8, 3'b110, randImm()));
    emit(encI(cpuPkg::opAluImm, 5'd10, 5'd9, 3'b111, randImm()));
    emit(encS(cpuPkg::opStore, 5'd0, 5'd10, 3'b010, addrA));
    emit(encS(cpuPkg::opStore, 5'd0, 5'd3, 3'b010, addrA + 12'd1));
    emit(encI(cpuPkg::opLoad, 5'd11, 5'd0, 3'b010, addrA));
    emit(encI(cpuPkg::opAluImm, 5'd12, 5'd0, 3'b000, randImm())); // load spacing
    emit(encR(7'h00, 5'd13, 5'd11, 5'd12, 3'b000));
    emit(encI(cpuPkg::opLoad, 5'd14, 5'd0, 3'b010, addrA + 12'd1));
    emit(encI(cpuPkg::opAluImm, 5'd0, 5'd0, 3'b000, randImm())); // x0 write
    emit(encR(7'h00, 5'd15, 5'd14, 5'd0, 3'b000));
    emit(encS(cpuPkg::opBranch, 5'd1, 5'd1, 3'b000, 12'd3));
    emit(encI(cpuPkg::opAluImm, 5'd1, 5'd0, 3'b000, 12'd5)); // squashed
    emit(encS(cpuPkg::opStore, 5'd0, 5'd1, 3'b010, 12'd0));    // squashed
    emit(encS(cpuPkg::opBranch, 5'd1, 5'd2, 3'b000, 12'd2));
    emit(encR(7'h00, 5'd1, 5'd0, 5'd13, 3'b110));
    emit(encS(cpuPkg::opBranch, 5'd0, 5'd0, 3'b000, 12'd0)); // spin in place
    emit(32'h0);
    emit(32'h0);
  endtask

  // in-order ISA run, squashed slots simply never execute
  task automatic runModel();
    logic [31:0] regs [32];
    logic [31:0] refMem [logic [31:0]];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] val;
    int          pc;
    int          steps;
    bit          halted;
    regs = '{default: '0};
    val = '0;
    pc = 0;
    steps = 0;
    halted = 1'b0;
    while (!halted && pc < progLen && steps < 200) begin
      w = progMem[pc];
      a = regs[w[19:15]];
      b = regs[w[24:20]];
      immI = {{20{w[31]}}, w[31:20]};
      immS = {{20{w[31]}}, w[31:25], w[11:7]};
      pc++;
      steps++;
      case (w[6:0])
        cpuPkg::opAluReg: val = aluRef(w[14:12], w[30], a, b);
        cpuPkg::opAluImm: val = aluRef(w[14:12], 1'b0, a, immI);
        cpuPkg::opLoad:   val = refMem[a + immI];
        cpuPkg::opStore: begin
          refMem[a + immS] = b;
          expAddr.push_back(a + immS);
          expStore.push_back(b);
        end
        cpuPkg::opBranch: begin
          if (a == b) begin
            halted = (immS == '0);
            pc = pc - 1 + int'(immS);
          end
        end
        default: ;
      endcase
      if (w[6:0] inside {cpuPkg::opAluReg, cpuPkg::opAluImm, cpuPkg::opLoad}) begin
        expRd.push_back(w[11:7]);
        expData.push_back(val);
        if (w[11:7] != 5'd0) regs[w[11:7]] = val;
      end
    end
  endtask

  task automatic checkRetire();
    logic [4:0]  rd;
    logic [31:0] data;
    if (expRd.size() == 0) begin
      retireErrs++;
      $display("retire to x%0d seen but the model expects no more writes", retire.rd);
      return;
    end
    rd = expRd.pop_front();
    data = expData.pop_front();
    assert (retire.rd === rd) else begin
      retireErrs++;
      $display("Fail retire.rd: got %h expected %h", retire.rd, rd);
    end
    assert (retire.data === data) else begin
      retireErrs++;
      $display("Fail retire.data: got %h expected %h", retire.data, data);
    end
  endtask

  task automatic checkStore();
    logic [31:0] addr;
    logic [31:0] data;
    if (expAddr.size() == 0) begin
      storeErrs++;
      $display("store to %0h seen but the model expects no more stores", store.addr);
      return;
    end
    addr = expAddr.pop_front();
    data = expStore.pop_front();
    assert (store.addr === addr) else begin
      storeErrs++;
      $display("Fail store.addr: got %h expected %h", store.addr, addr);
    end
    assert (store.data === data) else begin
      storeErrs++;
      $display("Fail store.data: got %h expected %h", store.data, data);
    end
  endtask

  // mid-cycle sampling, outputs settle after the rising edge
  always @(negedge clk) begin
    if (rst && retire.valid) checkRetire();
    if (rst && store.valid) checkStore();
  end

  initial begin
    rst = 1'b0;
    prog = '0;
    buildProgram();
    runModel();
    for (int i = 0; i < progLen; i++) begin
      @(posedge clk);
      prog <= '{we: 1'b1, addr: 32'(i), data: progMem[i]};
    end
    @(posedge clk);
    prog <= '0;
    repeat (2) @(posedge clk); // reset held two cycles past the load
    rst <= 1'b1;
    waitCycles = 0;
    while ((expRd.size() + expAddr.size()) != 0 && waitCycles < 300) begin
      @(posedge clk);
      waitCycles++;
    end
    if ((expRd.size() + expAddr.size()) != 0) begin
      timeouts++;
      $display("timed out with %0d retires and %0d stores still outstanding",
               expRd.size(), expAddr.size());
    end
    repeat (8) @(posedge clk); // catch stray events past the last one
    $display("errors: retire %0d store %0d assert %0d timeout %0d",
             retireErrs, storeErrs, dut.checks.failCount, timeouts);
    if (retireErrs + storeErrs + timeouts + dut.checks.failCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* test/pipeCpu_assert.sv */
`timescale 1ns/1ps

module pipeCpu_assert (
  input logic           clk,
  input logic           rst,
  input cpuPkg::retireT retire,
  input cpuPkg::storeT  store
);

  int         failCount = 0;
  logic [2:0] sinceRst; // edges since release, saturates

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) sinceRst <= '0;
    else if (sinceRst != 3'd7) sinceRst <= sinceRst + 3'd1;
  end

  // first writeback lands after the fourth edge
  quietRetire: assert property (@(posedge clk) sinceRst < 3'd4 |-> !retire.valid)
    else begin
      failCount = failCount + 1;
      $error("retire.valid high during reset or too soon after release");
    end

  // a store sits in the memory stage one edge earlier
  quietStore: assert property (@(posedge clk) sinceRst < 3'd3 |-> !store.valid)
    else begin
      failCount = failCount + 1;
      $error("store.valid high during reset or too soon after release");
    end

  knownRetire: assert property (@(posedge clk) disable iff (!rst)
                                retire.valid |-> !$isunknown({retire.rd, retire.data}))
    else begin
      failCount = failCount + 1;
      $error("retire fields unknown while valid");
    end

  knownStore: assert property (@(posedge clk) disable iff (!rst)
                               store.valid |-> !$isunknown({store.addr, store.data}))
    else begin
      failCount = failCount + 1;
      $error("store fields unknown while valid");
    end

endmodule

bind pipeCpu pipeCpu_assert checks (
  .clk    (clk),
  .rst    (rst),
  .retire (retire),
  .store  (store)
);

/* hdl/pipeCpu.sv */
`timescale 1ns/1ps

module pipeCpu (
  input  logic           clk,
  input  logic           rst,
  input  cpuPkg::progT   prog,
  output cpuPkg::retireT retire,
  output cpuPkg::storeT  store
);

  logic [cpuPkg::xlen-1:0] instr;
  logic [cpuPkg::xlen-1:0] pc;
  logic                    redirect;
  logic [cpuPkg::xlen-1:0] target;
  cpuPkg::deRegT           de;
  cpuPkg::emRegT           em;
  cpuPkg::wbBusT           wb;

  fetchStage fetch (
    .clk      (clk),
    .rst      (rst),
    .prog     (prog),
    .redirect (redirect),
    .target   (target),
    .instr    (instr),
    .pc       (pc)
  );

  decodeStage decode (
    .clk   (clk),
    .rst   (rst),
    .instr (instr),
    .pc    (pc),
    .wb    (wb),
    .de    (de)
  );

  executeStage execute (
    .clk      (clk),
    .rst      (rst),
    .de       (de),
    .wb       (wb),
    .em       (em),
    .redirect (redirect),
    .target   (target)
  );

  memoryStage memory (
    .clk   (clk),
    .rst   (rst),
    .em    (em),
    .wb    (wb),
    .store (store)
  );

  // every writeback retires, x0 included
  assign retire.valid = wb.regWrite;
  assign retire.rd    = wb.rd;
  assign retire.data  = wb.data;

endmodule

/* hdl/memoryStage.sv */
`timescale 1ns/1ps

module memoryStage (
  input  logic          clk,
  input  logic          rst,
  input  cpuPkg::emRegT em,
  output cpuPkg::wbBusT wb,
  output cpuPkg::storeT store
);

  logic [cpuPkg::xlen-1:0] dmem [cpuPkg::dmemDepth];
  logic [cpuPkg::dmemAw-1:0] wordAddr;
  logic [cpuPkg::xlen-1:0] readData;

  logic                        wbRegWrite;
  logic                        wbMemToReg;
  logic [cpuPkg::regAddrW-1:0] wbRd;
  logic [cpuPkg::xlen-1:0]     wbAlu;
  logic [cpuPkg::xlen-1:0]     wbLoad;

  assign wordAddr = em.aluResult[cpuPkg::dmemAw-1:0];

  always_ff @(posedge clk) begin
    if (em.memWrite) begin
      dmem[wordAddr] <= em.storeData;
    end
  end

  assign readData = dmem[wordAddr]; // async read

  assign store.valid = em.memWrite;
  assign store.addr  = em.aluResult;
  assign store.data  = em.storeData;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      wbRegWrite <= 1'b0;
      wbMemToReg <= 1'b0;
      wbRd       <= '0;
      wbAlu      <= '0;
      wbLoad     <= '0;
    end else begin
      wbRegWrite <= em.regWrite;
      wbMemToReg <= em.memToReg;
      wbRd       <= em.rd;
      wbAlu      <= em.aluResult;
      wbLoad     <= readData;
    end
  end

  // result select
  assign wb.regWrite = wbRegWrite;
  assign wb.rd       = wbRd;
  assign wb.data     = wbMemToReg ? wbLoad : wbAlu;

endmodule

/* hdl/executeStage.sv */
`timescale 1ns/1ps

module executeStage (
  input  logic                    clk,
  input  logic                    rst,
  input  cpuPkg::deRegT           de,
  input  cpuPkg::wbBusT           wb,
  output cpuPkg::emRegT           em,
  output logic                    redirect,
  output logic [cpuPkg::xlen-1:0] target
);

  cpuPkg::fwdSelT fwdA;
  cpuPkg::fwdSelT fwdB;
  logic [cpuPkg::xlen-1:0] srcA;
  logic [cpuPkg::xlen-1:0] rs2Fwd;
  logic [cpuPkg::xlen-1:0] srcB;
  logic [cpuPkg::xlen-1:0] aluResult;
  logic                    aluZero;
  logic [1:0]              squashCnt; // younger slots left to kill
  logic                    squashNow;

  // memory stage wins over writeback, x0 never forwards
  function automatic cpuPkg::fwdSelT pickFwd(
    input logic [cpuPkg::regAddrW-1:0] src,
    input cpuPkg::emRegT               memSt,
    input cpuPkg::wbBusT               wbSt
  );
    if (memSt.regWrite && memSt.rd != '0 && memSt.rd == src) return cpuPkg::fwdMem;
    if (wbSt.regWrite && wbSt.rd != '0 && wbSt.rd == src) return cpuPkg::fwdWb;
    return cpuPkg::fwdNone;
  endfunction

  function automatic logic [cpuPkg::xlen-1:0] fwdMux(
    input cpuPkg::fwdSelT          sel,
    input logic [cpuPkg::xlen-1:0] regVal,
    input logic [cpuPkg::xlen-1:0] memVal,
    input logic [cpuPkg::xlen-1:0] wbVal
  );
    case (sel)
      cpuPkg::fwdMem: return memVal;
      cpuPkg::fwdWb:  return wbVal;
      default:        return regVal;
    endcase
  endfunction

  assign fwdA = pickFwd(de.rs1, em, wb);
  assign fwdB = pickFwd(de.rs2, em, wb);

  assign srcA   = fwdMux(fwdA, de.rs1Data, em.aluResult, wb.data);
  assign rs2Fwd = fwdMux(fwdB, de.rs2Data, em.aluResult, wb.data);
  assign srcB   = de.ctrl.aluSrcImm ? de.imm : rs2Fwd;

  aluUnit alu (
    .a      (srcA),
    .b      (srcB),
    .op     (de.ctrl.aluOp),
    .result (aluResult),
    .zero   (aluZero)
  );

  assign squashNow = (squashCnt != 2'd0);
  assign redirect  = de.ctrl.branch && aluZero && !squashNow; // squashed beq ignored
  assign target    = de.pc + de.imm;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      squashCnt <= 2'd0;
    end else if (redirect) begin
      squashCnt <= 2'd2;
    end else if (squashNow) begin
      squashCnt <= squashCnt - 2'd1;
    end
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      em <= '0;
    end else begin
      em.regWrite  <= de.ctrl.regWrite && !squashNow;
      em.memWrite  <= de.ctrl.memWrite && !squashNow;
      em.memToReg  <= de.ctrl.memToReg;
      em.rd        <= de.rd;
      em.aluResult <= aluResult;
      em.storeData <= rs2Fwd;
    end
  end

endmodule

/* hdl/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [cpuPkg::xlen-1:0] instr,
  input  logic [cpuPkg::xlen-1:0] pc,
  input  cpuPkg::wbBusT           wb,
  output cpuPkg::deRegT           de
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7b5;
  logic [cpuPkg::regAddrW-1:0] rs1;
  logic [cpuPkg::regAddrW-1:0] rs2;
  logic [cpuPkg::regAddrW-1:0] rd;
  cpuPkg::ctrlT  ctrl;
  cpuPkg::aluOpT aluSel;
  logic          storeFmt;
  logic [cpuPkg::xlen-1:0] imm;
  logic [cpuPkg::xlen-1:0] rs1Val;
  logic [cpuPkg::xlen-1:0] rs2Val;
  logic [cpuPkg::xlen-1:0] regFile [2**cpuPkg::regAddrW];

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];
  assign rd       = instr[11:7];
  assign rs1      = instr[19:15];
  assign rs2      = instr[24:20];

  // alu op from funct fields, sub only for the register form
  always_comb begin
    case (funct3)
      3'b000:  aluSel = (opcode == cpuPkg::opAluReg && funct7b5) ? cpuPkg::aluSub
                                                                 : cpuPkg::aluAdd;
      3'b100:  aluSel = cpuPkg::aluXor;
      3'b110:  aluSel = cpuPkg::aluOr;
      3'b111:  aluSel = cpuPkg::aluAnd;
      default: aluSel = cpuPkg::aluAdd;
    endcase
  end

  always_comb begin
    ctrl     = '0;
    storeFmt = 1'b0;
    case (opcode)
      cpuPkg::opLoad: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.memToReg  = 1'b1;
      end
      cpuPkg::opStore: begin
        ctrl.aluSrcImm = 1'b1;
        ctrl.memWrite  = 1'b1;
        storeFmt       = 1'b1;
      end
      cpuPkg::opBranch: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp  = cpuPkg::aluSub; // equal means zero difference
        storeFmt    = 1'b1;
      end
      cpuPkg::opAluReg: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp    = aluSel;
      end
      cpuPkg::opAluImm: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
        ctrl.aluOp     = aluSel;
      end
      default: ctrl = '0;
    endcase
  end

  // branch reuses the store immediate layout
  assign imm = storeFmt ? {{20{instr[31]}}, instr[31:25], instr[11:7]}
                        : {{20{instr[31]}}, instr[31:20]};

  always_ff @(posedge clk) begin
    if (wb.regWrite && wb.rd != '0) begin
      regFile[wb.rd] <= wb.data;
    end
  end

  // x0 reads as zero, writeback value passes straight through
  always_comb begin
    if (rs1 == '0) rs1Val = '0;
    else if (wb.regWrite && wb.rd == rs1) rs1Val = wb.data;
    else rs1Val = regFile[rs1];
    if (rs2 == '0) rs2Val = '0;
    else if (wb.regWrite && wb.rd == rs2) rs2Val = wb.data;
    else rs2Val = regFile[rs2];
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      de <= '0;
    end else begin
      de.ctrl    <= ctrl;
      de.rs1Data <= rs1Val;
      de.rs2Data <= rs2Val;
      de.imm     <= imm;
      de.pc      <= pc;
      de.rs1     <= rs1;
      de.rs2     <= rs2;
      de.rd      <= rd;
    end
  end

endmodule

/* hdl/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage (
  input  logic                    clk,
  input  logic                    rst,
  input  cpuPkg::progT            prog,
  input  logic                    redirect,
  input  logic [cpuPkg::xlen-1:0] target,
  output logic [cpuPkg::xlen-1:0] instr,
  output logic [cpuPkg::xlen-1:0] pc
);

  logic [cpuPkg::xlen-1:0] pcF;
  logic [cpuPkg::xlen-1:0] pcNext;
  logic [cpuPkg::xlen-1:0] instrF;
  logic [cpuPkg::xlen-1:0] imem [cpuPkg::imemDepth];

  // pc counts words
  assign pcNext = redirect ? target : pcF + 1;

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcF <= '0;
    end else begin
      pcF <= pcNext;
    end
  end

  // program load port
  always_ff @(posedge clk) begin
    if (prog.we) begin
      imem[prog.addr[cpuPkg::imemAw-1:0]] <= prog.data;
    end
  end

  assign instrF = imem[pcF[cpuPkg::imemAw-1:0]];

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      instr <= '0; // opcode 0 decodes as a no-op
      pc    <= '0;
    end else begin
      instr <= instrF;
      pc    <= pcF;
    end
  end

endmodule

/* hdl/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
  input  logic [cpuPkg::xlen-1:0] a,
  input  logic [cpuPkg::xlen-1:0] b,
  input  cpuPkg::aluOpT           op,
  output logic [cpuPkg::xlen-1:0] result,
  output logic                    zero
);

  logic [cpuPkg::xlen-1:0] sum;
  logic [cpuPkg::xlen-1:0] diff;

  assign sum  = a + b;
  assign diff = a - b;

  always_comb begin
    case (op)
      cpuPkg::aluAdd: result = sum;
      cpuPkg::aluSub: result = diff;
      cpuPkg::aluXor: result = a ^ b;
      cpuPkg::aluOr:  result = a | b;
      cpuPkg::aluAnd: result = a & b;
      default:        result = '0;
    endcase
  end

  // used by beq through the sub path
  assign zero = (result == '0);

endmodule

/* hdl/cpuPkg.sv */
package cpuPkg;

  localparam int xlen = 32;
  localparam int regAddrW = 5;
  localparam int imemDepth = 1024;
  localparam int dmemDepth = 1024;
  localparam int imemAw = $clog2(imemDepth);
  localparam int dmemAw = $clog2(dmemDepth);

  // opcode field values
  localparam logic [6:0] opLoad = 7'b0000011;
  localparam logic [6:0] opStore = 7'b0100011;
  localparam logic [6:0] opBranch = 7'b1100011;
  localparam logic [6:0] opAluReg = 7'b0110011;
  localparam logic [6:0] opAluImm = 7'b0010011;

  typedef enum logic [3:0] {
    aluAdd = 4'd0,
    aluSub = 4'd1,
    aluXor = 4'd2,
    aluOr  = 4'd3,
    aluAnd = 4'd4
  } aluOpT;

  typedef enum logic [1:0] {
    fwdNone = 2'd0,
    fwdWb   = 2'd1,
    fwdMem  = 2'd2
  } fwdSelT;

  typedef struct packed {
    logic  regWrite;
    logic  aluSrcImm; // b operand from imm
    logic  memWrite;
    logic  memToReg;
    logic  branch;
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    ctrlT                ctrl;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     pc;
    logic [regAddrW-1:0] rs1;
    logic [regAddrW-1:0] rs2;
    logic [regAddrW-1:0] rd;
  } deRegT;

  typedef struct packed {
    logic                regWrite;
    logic                memWrite;
    logic                memToReg;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     aluResult;
    logic [xlen-1:0]     storeData;
  } emRegT;

  typedef struct packed {
    logic                regWrite;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     data;
  } wbBusT;

  typedef struct packed {
    logic                valid;
    logic [regAddrW-1:0] rd;
    logic [xlen-1:0]     data;
  } retireT;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] addr; // word address
    logic [xlen-1:0] data;
  } storeT;

  typedef struct packed {
    logic            we;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
  } progT;

endpackage
